//--- design/mif_ctrl_pkg.sv
package mif_ctrl_pkg;

    ////////////////////
    // widths
    ////////////////////
    localparam int ADDR_WIDTH    = 12;  // basic block offset
    localparam int DATA_WIDTH    = 16;  // basic block data word
    localparam int BASE_WIDTH    = 32;  // stream base address
    localparam int WB_ADDR_WIDTH = 13;  // msb selects direct access

    // anything outside these controller register offsets is illegal
    typedef enum logic [ADDR_WIDTH-1:0] {
        REG_BASE = 12'd0,
        REG_CTRL = 12'd1,
        REG_ERR  = 12'd2
    } reg_offset_e;

    // basic block opcodes
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } basic_op_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_CHECK,    // look up rmw table
        S_READ,     // issue basic read
        S_WRITE,    // issue basic write
        S_WAIT_BB,  // wait for ctrl_wait to drop
        S_MODIFY,   // merge saved data with new data
        S_WAIT_AV   // wait for next stream request
    } ctrl_state_e;

    // which source loads the access address and data
    typedef enum logic [1:0] {
        LOAD_NONE,
        LOAD_DIR,
        LOAD_AV
    } load_sel_e;

    // error register bits
    localparam int ERR_BAD_OFFSET = 0;
    localparam int ERR_OPCODE     = 1;

    ////////////////////
    // rmw protection table
    ////////////////////
    localparam int NUM_RMW = 4;

    localparam logic [ADDR_WIDTH-1:0] RMW_OFFSETS [NUM_RMW] = '{
        12'h084, 12'h0A1, 12'h0B3, 12'h0C0
    };

    // set bits keep their old value
    localparam logic [DATA_WIDTH-1:0] RMW_MASKS [NUM_RMW] = '{
        16'hF000, 16'h00FF, 16'h8001, 16'h0F0F
    };

endpackage

//--- design/uif_regs.sv
`timescale 1ns/10ps

module uif_regs #(
    parameter int ADDR_WIDTH = mif_ctrl_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH = mif_ctrl_pkg::DATA_WIDTH
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 wb_cyc,
    input  logic                                 wb_stb,
    input  logic                                 wb_we,
    input  logic [mif_ctrl_pkg::WB_ADDR_WIDTH-1:0] wb_adr,
    input  logic [31:0]                          wb_wdata,
    output logic [31:0]                          wb_rdata,
    output logic                                 wb_ack,
    output logic [mif_ctrl_pkg::BASE_WIDTH-1:0]  base_addr,
    output logic                                 addr_mode,
    output logic                                 op_err,
    input  logic                                 av_opcode_err,
    output logic                                 strm_start,
    output logic                                 dir_req,
    output logic                                 dir_we,
    output logic [ADDR_WIDTH-1:0]                dir_addr,
    output logic [DATA_WIDTH-1:0]                dir_wdata,
    input  logic                                 dir_done,
    input  logic [DATA_WIDTH-1:0]                ctrl_rdata
);
    import mif_ctrl_pkg::*;

    logic        wb_open;      // cycle accepted and ack not yet given
    logic        accept;
    logic        reg_acc;
    logic        reg_wr;
    logic        bad_off;
    logic        err_clr;
    logic [1:0]  err_flags;
    logic [1:0]  err_set;
    logic [31:0] reg_rd_val;
    reg_offset_e reg_off;

    assign accept  = wb_cyc & wb_stb & ~wb_open;
    assign reg_acc = accept & ~wb_adr[WB_ADDR_WIDTH-1];
    assign reg_wr  = reg_acc & wb_we;
    assign reg_off = reg_offset_e'(wb_adr[$bits(reg_offset_e)-1:0]);

    // master holds address and data of a direct access until ack
    assign dir_req   = accept & wb_adr[WB_ADDR_WIDTH-1];
    assign dir_we    = wb_we;
    assign dir_addr  = wb_adr[ADDR_WIDTH-1:0];
    assign dir_wdata = wb_wdata[DATA_WIDTH-1:0];

    // register read mux and offset check
    always_comb begin
        bad_off    = 1'b0;
        reg_rd_val = '0;
        case (reg_off)
            REG_BASE: reg_rd_val = 32'(base_addr);
            REG_CTRL: reg_rd_val = {30'd0, addr_mode, 1'b0};
            REG_ERR:  reg_rd_val = 32'(err_flags);
            default:  bad_off = 1'b1;  // read returns 0
        endcase
    end

    always_comb begin
        err_set                 = '0;
        err_set[ERR_BAD_OFFSET] = reg_acc & bad_off;
        err_set[ERR_OPCODE]     = av_opcode_err;
    end

    ////////////////////
    // registers
    ////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_open    <= 1'b0;
            wb_ack     <= 1'b0;
            base_addr  <= '0;
            addr_mode  <= 1'b0;
            strm_start <= 1'b0;
            err_clr    <= 1'b0;
            err_flags  <= '0;
        end else begin
            if (accept)
                wb_open <= 1'b1;
            else if (wb_ack)
                wb_open <= 1'b0;
            wb_ack <= reg_acc | dir_done;  // fixed latency for registers

            if (reg_wr && reg_off == REG_BASE)
                base_addr <= wb_wdata[BASE_WIDTH-1:0];
            if (reg_wr && reg_off == REG_CTRL)
                addr_mode <= wb_wdata[1];

            // start and clear are strobes
            strm_start <= reg_wr & (reg_off == REG_CTRL) & wb_wdata[0];
            err_clr    <= reg_wr & (reg_off == REG_CTRL) & wb_wdata[2];

            err_flags <= (err_clr ? 2'b00 : err_flags) | err_set;  // sticky
        end
    end

    always_ff @(posedge clk) begin
        if (reg_acc && !wb_we)
            wb_rdata <= reg_rd_val;
        else if (dir_done && !wb_we)
            wb_rdata <= 32'(ctrl_rdata);  // basic block data on completion
    end

    assign op_err = |err_flags;

endmodule

//--- design/ctrl_fsm.sv
`timescale 1ns/10ps

module ctrl_fsm (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    strm_start,
    input  logic                    dir_req,
    input  logic                    dir_we,
    output logic                    dir_done,
    input  logic                    av_req,
    input  logic                    av_done,
    output logic                    stream_go,
    output logic                    op_done,
    output logic                    busy,
    input  logic                    rmw_hit,
    output mif_ctrl_pkg::load_sel_e load_addr,
    output logic                    merge_en,
    output logic                    ctrl_go,
    output mif_ctrl_pkg::basic_op_e ctrl_opcode,
    input  logic                    ctrl_wait
);
    import mif_ctrl_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;

    logic av_req_q;   // delayed copy for edge detect
    logic av_rise;
    logic av_pend;    // stream request seen, not yet taken
    logic dir_pend;   // direct request arrived while busy
    logic is_dir;     // current access came from the user
    logic rmw_pend;   // read phase of a read-modify-write
    logic done_now;

    assign av_rise = av_req & ~av_req_q;

    ////////////////////
    // next state
    ////////////////////
    always_comb begin
        state_nxt = state;
        load_addr = LOAD_NONE;
        case (state)
            S_IDLE: begin
                if (strm_start)
                    state_nxt = S_WAIT_AV;
                else if (dir_req || dir_pend) begin
                    load_addr = LOAD_DIR;
                    state_nxt = dir_we ? S_CHECK : S_READ;  // reads skip the check
                end
            end
            S_WAIT_AV: begin
                if (av_done)
                    state_nxt = S_IDLE;
                else if (av_rise || av_pend) begin
                    load_addr = LOAD_AV;
                    state_nxt = S_CHECK;
                end
            end
            S_CHECK:  state_nxt = rmw_hit ? S_READ : S_WRITE;
            S_READ:   state_nxt = S_WAIT_BB;
            S_WRITE:  state_nxt = S_WAIT_BB;
            S_WAIT_BB: begin
                if (!ctrl_wait) begin
                    if (rmw_pend)
                        state_nxt = S_MODIFY;
                    else if (is_dir)
                        state_nxt = S_IDLE;
                    else
                        state_nxt = S_WAIT_AV;
                end
            end
            S_MODIFY: state_nxt = S_WRITE;
            default:  state_nxt = S_IDLE;
        endcase
    end

    ////////////////////
    // state and control regs
    ////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= S_IDLE;
            av_req_q    <= 1'b0;
            av_pend     <= 1'b0;
            dir_pend    <= 1'b0;
            is_dir      <= 1'b0;
            rmw_pend    <= 1'b0;
            ctrl_go     <= 1'b0;
            ctrl_opcode <= OP_READ;
            stream_go   <= 1'b0;
            busy        <= 1'b0;
        end else begin
            state    <= state_nxt;
            av_req_q <= av_req;

            if (load_addr == LOAD_AV)
                av_pend <= 1'b0;
            else if (av_rise)
                av_pend <= 1'b1;

            if (load_addr == LOAD_DIR)
                dir_pend <= 1'b0;
            else if (dir_req)
                dir_pend <= 1'b1;

            if (load_addr == LOAD_DIR)
                is_dir <= 1'b1;
            else if (load_addr == LOAD_AV)
                is_dir <= 1'b0;

            if (state == S_CHECK && rmw_hit)
                rmw_pend <= 1'b1;
            else if (state == S_MODIFY)
                rmw_pend <= 1'b0;

            // go is high for the single issue cycle
            ctrl_go <= (state_nxt == S_READ) || (state_nxt == S_WRITE);
            if (state_nxt == S_WRITE)
                ctrl_opcode <= OP_WRITE;
            else if (state_nxt == S_READ)
                ctrl_opcode <= OP_READ;

            stream_go <= (state == S_IDLE) & strm_start;
            busy      <= (state != S_IDLE);
        end
    end

    // completion in the cycle ctrl_wait drops
    assign done_now = (state == S_WAIT_BB) & ~ctrl_wait & ~rmw_pend;
    assign dir_done = done_now & is_dir;
    assign op_done  = done_now & ~is_dir;
    assign merge_en = (state == S_MODIFY);

endmodule

//--- design/basic_access.sv
`timescale 1ns/10ps

module basic_access #(
    parameter int ADDR_WIDTH = mif_ctrl_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH = mif_ctrl_pkg::DATA_WIDTH
) (
    input  logic                    clk,
    input  logic                    reset,
    input  mif_ctrl_pkg::load_sel_e load_addr,
    input  logic                    merge_en,
    input  logic [ADDR_WIDTH-1:0]   dir_addr,
    input  logic [DATA_WIDTH-1:0]   dir_wdata,
    input  logic [ADDR_WIDTH-1:0]   av_addr,
    input  logic [DATA_WIDTH-1:0]   av_data,
    input  mif_ctrl_pkg::basic_op_e ctrl_opcode,
    input  logic                    ctrl_wait,
    input  logic [DATA_WIDTH-1:0]   ctrl_rdata,
    output logic                    rmw_hit,
    output logic [ADDR_WIDTH-1:0]   ctrl_addr,
    output logic [DATA_WIDTH-1:0]   ctrl_wdata
);
    import mif_ctrl_pkg::*;

    logic [DATA_WIDTH-1:0] rmw_mask;
    logic [DATA_WIDTH-1:0] saved_rdata;  // old word for the merge
    logic                  wait_q;
    logic                  rd_done;

    ////////////////////
    // mask lookup
    ////////////////////
    always_comb begin
        rmw_hit  = 1'b0;
        rmw_mask = '0;  // all bits writable
        for (int i = 0; i < NUM_RMW; i++) begin
            if (ctrl_addr == ADDR_WIDTH'(RMW_OFFSETS[i])) begin
                rmw_hit  = 1'b1;
                rmw_mask = DATA_WIDTH'(RMW_MASKS[i]);
            end
        end
    end

    // falling ctrl_wait ends the access
    assign rd_done = wait_q & ~ctrl_wait & (ctrl_opcode == OP_READ);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wait_q     <= 1'b0;
            ctrl_addr  <= '0;
            ctrl_wdata <= '0;
        end else begin
            wait_q <= ctrl_wait;
            case (load_addr)
                LOAD_DIR: begin
                    ctrl_addr  <= dir_addr;
                    ctrl_wdata <= dir_wdata;
                end
                LOAD_AV: begin
                    ctrl_addr  <= av_addr;
                    ctrl_wdata <= av_data;
                end
                default: begin
                    // masked bits come from the word just read
                    if (merge_en)
                        ctrl_wdata <= (ctrl_wdata & ~rmw_mask) | (saved_rdata & rmw_mask);
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_done)
            saved_rdata <= ctrl_rdata;
    end

endmodule

//--- design/mif_ctrl_top.sv
`timescale 1ns/10ps

module mif_ctrl_top #(
    parameter int ADDR_WIDTH = mif_ctrl_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH = mif_ctrl_pkg::DATA_WIDTH
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   wb_cyc,
    input  logic                                   wb_stb,
    input  logic                                   wb_we,
    input  logic [mif_ctrl_pkg::WB_ADDR_WIDTH-1:0] wb_adr,
    input  logic [31:0]                            wb_wdata,
    output logic [31:0]                            wb_rdata,
    output logic                                   wb_ack,
    output logic [mif_ctrl_pkg::BASE_WIDTH-1:0]    base_addr,
    output logic                                   addr_mode,
    output logic                                   stream_go,
    output logic                                   busy,
    output logic                                   op_done,
    output logic                                   op_err,
    input  logic                                   av_req,
    input  logic [ADDR_WIDTH-1:0]                  av_addr,
    input  logic [DATA_WIDTH-1:0]                  av_data,
    input  logic                                   av_done,
    input  logic                                   av_opcode_err,
    output logic                                   ctrl_go,
    output mif_ctrl_pkg::basic_op_e                ctrl_opcode,
    output logic [ADDR_WIDTH-1:0]                  ctrl_addr,
    output logic [DATA_WIDTH-1:0]                  ctrl_wdata,
    input  logic                                   ctrl_wait,
    input  logic [DATA_WIDTH-1:0]                  ctrl_rdata
);
    import mif_ctrl_pkg::*;

    logic                  strm_start;
    logic                  dir_req;
    logic                  dir_we;
    logic                  dir_done;
    logic [ADDR_WIDTH-1:0] dir_addr;
    logic [DATA_WIDTH-1:0] dir_wdata;
    logic                  rmw_hit;
    logic                  merge_en;
    load_sel_e             load_addr;

    ////////////////////
    // user side
    ////////////////////
    uif_regs #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_uif_regs (
        .clk, .reset,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_rdata, .wb_ack,
        .base_addr, .addr_mode, .op_err, .av_opcode_err,
        .strm_start, .dir_req, .dir_we, .dir_addr, .dir_wdata, .dir_done,
        .ctrl_rdata
    );

    ctrl_fsm u_ctrl_fsm (
        .clk, .reset,
        .strm_start, .dir_req, .dir_we, .dir_done,
        .av_req, .av_done, .stream_go, .op_done, .busy,
        .rmw_hit, .load_addr, .merge_en,
        .ctrl_go, .ctrl_opcode, .ctrl_wait
    );

    // basic block address and data path
    basic_access #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_basic_access (
        .clk, .reset,
        .load_addr, .merge_en,
        .dir_addr, .dir_wdata, .av_addr, .av_data,
        .ctrl_opcode, .ctrl_wait, .ctrl_rdata,
        .rmw_hit, .ctrl_addr, .ctrl_wdata
    );

endmodule

//--- verification/mif_ctrl_assert.sv
`timescale 1ns/10ps

module mif_ctrl_assert (
    input logic clk,
    input logic reset,
    input logic ctrl_go,
    input logic ctrl_wait,
    input logic wb_stb,
    input logic wb_ack
);

    // go is a single cycle strobe
    go_one_cycle: assert property (@(posedge clk) disable iff (reset) ctrl_go |=> !ctrl_go)
        else $error("ctrl_go high for more than one cycle");

    go_not_waiting: assert property (@(posedge clk) disable iff (reset) ctrl_go |-> !ctrl_wait)
        else $error("ctrl_go issued while ctrl_wait is high");

    ack_needs_stb: assert property (@(posedge clk) disable iff (reset) wb_ack |-> wb_stb)
        else $error("wb_ack high without wb_stb");

endmodule

bind mif_ctrl_top mif_ctrl_assert u_mif_ctrl_assert (
    .clk(clk), .reset(reset), .ctrl_go(ctrl_go), .ctrl_wait(ctrl_wait),
    .wb_stb(wb_stb), .wb_ack(wb_ack)
);

//--- verification/tb_mif_ctrl.sv
`timescale 1ns/10ps

module tb_mif_ctrl;
    import mif_ctrl_pkg::*;

    logic                     clk;
    logic                     reset;
    logic                     wb_cyc, wb_stb, wb_we, wb_ack;
    logic [WB_ADDR_WIDTH-1:0] wb_adr;
    logic [31:0]              wb_wdata, wb_rdata;
    logic [BASE_WIDTH-1:0]    base_addr;
    logic                     addr_mode, stream_go, busy, op_done, op_err;
    logic                     av_req, av_done, av_opcode_err;
    logic [ADDR_WIDTH-1:0]    av_addr, ctrl_addr;
    logic [DATA_WIDTH-1:0]    av_data, ctrl_wdata, ctrl_rdata;
    logic                     ctrl_go, ctrl_wait;
    basic_op_e                ctrl_opcode;

    logic [DATA_WIDTH-1:0] mem [0:(1<<ADDR_WIDTH)-1];  // basic block contents
    logic [31:0]           pat [0:255];                // four words per pattern line
    logic [ADDR_WIDTH-1:0] strm_addr [$];
    logic [DATA_WIDTH-1:0] strm_data [$];
    logic [31:0]           rd_val;
    integer                seed = 32'hf362e1e9;
    int                    errors = 0;
    int                    checks = 0;
    int                    num_lines = 0;
    int                    cycles = 0;
    int                    limit = 0;

    mif_ctrl_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // one classic cycle held until ack
    task automatic wb_cycle(input logic dir, input logic we, input logic [31:0] a,
                            input logic [31:0] d);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= {dir, a[ADDR_WIDTH-1:0]};  // msb picks direct access
        wb_wdata <= d;
        do @(negedge clk); while (!wb_ack);
        rd_val = wb_rdata;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    ////////////////////
    // basic block target
    ////////////////////
    initial begin : bb_model
        basic_op_e             op;
        logic [ADDR_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] d;
        forever begin
            @(negedge clk);
            if (ctrl_go) begin
                op = ctrl_opcode;
                a  = ctrl_addr;
                d  = ctrl_wdata;
                @(posedge clk);
                ctrl_wait <= 1'b1;
                repeat (1 + $unsigned($random(seed)) % 4) @(posedge clk);  // 1 to 4
                if (op == OP_WRITE)
                    mem[a] = d;
                else
                    ctrl_rdata <= mem[a];
                ctrl_wait <= 1'b0;
            end
        end
    end

    // stream reader that plays the queued pairs after a start write
    task automatic run_stream(input logic opc_err);
        wb_cycle(1'b0, 1'b1, 32'h1, 32'h3);  // start with address mode set
        compare_value("addr_mode", 32'(addr_mode), 32'h1);
        do @(negedge clk); while (!stream_go);
        foreach (strm_addr[i]) begin
            @(posedge clk);
            av_req        <= 1'b1;
            av_addr       <= strm_addr[i];
            av_data       <= strm_data[i];
            av_opcode_err <= 1'b0;
            do @(negedge clk); while (!op_done);
            @(posedge clk);
            av_req        <= 1'b0;
            av_opcode_err <= opc_err && i == 0;  // one pulse mid stream
        end
        @(posedge clk);
        av_opcode_err <= 1'b0;
        av_done       <= 1'b1;
        @(posedge clk);
        av_done <= 1'b0;
        do @(negedge clk); while (busy);
        strm_addr.delete();
        strm_data.delete();
    endtask

    task automatic run_line(input logic [31:0] cmd, input logic [31:0] a,
                            input logic [31:0] d, input logic [31:0] exp);
        case (cmd)
            1: begin
                wb_cycle(1'b0, 1'b1, a, d);
                if (a[ADDR_WIDTH-1:0] == REG_BASE)
                    compare_value("base_addr", base_addr, d);
                else if (a[ADDR_WIDTH-1:0] == REG_CTRL)
                    compare_value("addr_mode", 32'(addr_mode), 32'(d[1]));
            end
            2: begin
                wb_cycle(1'b0, 1'b0, a, 32'h0);
                compare_value("register read", rd_val, exp);
            end
            3: wb_cycle(1'b1, 1'b1, a, d);
            4: begin
                wb_cycle(1'b1, 1'b0, a, 32'h0);
                compare_value("direct read", rd_val, exp);
            end
            5: mem[a[ADDR_WIDTH-1:0]] = d[DATA_WIDTH-1:0];
            6: begin
                strm_addr.push_back(a[ADDR_WIDTH-1:0]);
                strm_data.push_back(d[DATA_WIDTH-1:0]);
            end
            7: run_stream(d[0]);
            8: compare_value("memory word", 32'(mem[a[ADDR_WIDTH-1:0]]), exp);
            9: begin
                @(negedge clk);
                compare_value("op_err", 32'(op_err), exp);
            end
            default: begin
                $display("unknown pattern command %0h", cmd);
                errors++;
            end
        endcase
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        reset         = 1'b1;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_wdata      = '0;
        av_req        = 1'b0;
        av_addr       = '0;
        av_data       = '0;
        av_done       = 1'b0;
        av_opcode_err = 1'b0;
        ctrl_wait     = 1'b0;
        ctrl_rdata    = '0;
        for (int i = 0; i < (1 << ADDR_WIDTH); i++)
            mem[i] = 16'ha000 | 16'(i);  // fill word carries its own offset
        $readmemh("verification/mif_ctrl_patterns.txt", pat);
        while (num_lines < 64 && pat[4*num_lines] != 0)
            num_lines++;
        limit = 40 * num_lines;
        if (num_lines == 0) begin
            $display("no pattern lines read from verification/mif_ctrl_patterns.txt");
            errors++;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        for (int n = 0; n < num_lines; n++)
            run_line(pat[4*n], pat[4*n+1], pat[4*n+2], pat[4*n+3]);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    // cycle limit scales with the pattern count
    initial begin
        do begin
            @(posedge clk);
            cycles++;
        end while (cycles <= limit);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("sim failed");
        $finish;
    end

endmodule

//--- verification/mif_ctrl_patterns.txt
// columns: command offset data expected, all hex; commands: 1 reg write, 2 reg read,
// 3 direct write, 4 direct read, 5 preload, 6 stream pair, 7 run stream, 8 memory word, 9 op_err
2 002 0        0
1 000 12345678 0
2 000 0        12345678
2 005 0        0
2 002 0        1
9 000 0        1
1 001 4        0
2 002 0        0
9 000 0        0
3 010 c3a5     0
4 010 0        c3a5
5 084 5abc     0
3 084 ffff     0
8 084 0        5fff
4 084 0        5fff
5 0a1 1234     0
5 0b3 ffff     0
5 0c0 0        0
6 0a1 abcd     0
6 020 7777     0
6 0b3 0        0
6 0c0 ffff     0
7 000 0        0
8 0a1 0        ab34
8 020 0        7777
8 0b3 0        8001
8 0c0 0        f0f0
6 0a1 0        0
7 000 1        0
8 0a1 0        0034
2 002 0        2
9 000 0        1
0 000 0        0

//--- vlog.f
design/mif_ctrl_pkg.sv
design/uif_regs.sv
design/ctrl_fsm.sv
design/basic_access.sv
design/mif_ctrl_top.sv
verification/mif_ctrl_assert.sv
verification/tb_mif_ctrl.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_mif_ctrl -f vlog.f
out=$(./obj_dir/Vtb_mif_ctrl) || true
echo "$out"
echo "$out" | grep -qx "sim passed"
